// File: hw/ai_sequencer.sv
`timescale 1ns/10ps

module ai_sequencer (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  go,
	input  logic [othello_pkg::BOARD_BITS-1:0]    init_red,
	input  logic [othello_pkg::BOARD_BITS-1:0]    init_blue,
	input  logic                                  init_player,
	input  logic                                  found,
	input  logic [othello_pkg::COORD_BITS-1:0]    best_x_in,
	input  logic [othello_pkg::COORD_BITS-1:0]    best_y_in,
	input  logic [othello_pkg::BOARD_BITS-1:0]    res_red,
	input  logic [othello_pkg::BOARD_BITS-1:0]    res_blue,
	input  logic                                  res_valid,
	input  logic                                  w_valid,
	output logic [othello_pkg::COORD_BITS-1:0]    cand_x,
	output logic [othello_pkg::COORD_BITS-1:0]    cand_y,
	output logic                                  cand_valid,
	output logic                                  final_cand,
	output logic                                  sweep_start,
	output logic [othello_pkg::BOARD_BITS-1:0]    cur_red,
	output logic [othello_pkg::BOARD_BITS-1:0]    cur_blue,
	output logic                                  player,
	output logic [othello_pkg::COORD_BITS-1:0]    sel_x,
	output logic [othello_pkg::COORD_BITS-1:0]    sel_y,
	output logic                                  sel_valid,
	output logic                                  done,
	output logic                                  busy,
	output logic                                  no_move,
	output logic [othello_pkg::BOARD_BITS-1:0]    new_red,
	output logic [othello_pkg::BOARD_BITS-1:0]    new_blue,
	output logic [othello_pkg::COORD_BITS-1:0]    best_x,
	output logic [othello_pkg::COORD_BITS-1:0]    best_y
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SWEEP,
		S_FINAL,
		S_FINISH
	} state_t;

	state_t                             state;
	logic [othello_pkg::INDEX_BITS-1:0] idx;
	logic                               sweep_d;
	logic                               final_d;

	//////////////////////////////
	// Candidate drive
	//////////////////////////////

	assign busy = (state != S_IDLE);
	assign sweep_start = (state == S_IDLE) && go;

	// Second cycle of S_FINAL, best has settled by then
	assign final_cand = (state == S_FINAL) && idx[0] && found;
	assign cand_valid = (state == S_SWEEP) || final_cand;

	// Sweep walks the index, final replays the best square
	assign cand_x = (state == S_SWEEP) ? idx[othello_pkg::COORD_BITS-1:0] : best_x_in;
	assign cand_y = (state == S_SWEEP) ?
		idx[othello_pkg::INDEX_BITS-1:othello_pkg::COORD_BITS] : best_y_in;

	// Final apply never reaches the selector
	assign sel_valid = res_valid && w_valid && sweep_d;

	// Coordinates delayed to meet the results
	always_ff @(posedge clk) begin
		sel_x <= cand_x;
		sel_y <= cand_y;
	end

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			idx <= '0;
			sweep_d <= 1'b0;
			final_d <= 1'b0;
			done <= 1'b0;
			no_move <= 1'b0;
			player <= 1'b0;
			cur_red <= othello_pkg::OPEN_RED;
			cur_blue <= othello_pkg::OPEN_BLUE;
			new_red <= othello_pkg::OPEN_RED;
			new_blue <= othello_pkg::OPEN_BLUE;
			best_x <= '0;
			best_y <= '0;
		end else begin
			// Single cycle pulse
			done <= 1'b0;
			sweep_d <= (state == S_SWEEP);
			final_d <= final_cand;
			case (state)
				S_IDLE: begin
					// go is only seen here
					if (go) begin
						cur_red <= init_red;
						cur_blue <= init_blue;
						player <= init_player;
						idx <= '0;
						state <= S_SWEEP;
					end
				end
				S_SWEEP: begin
					// Wraps to 0 after the last square
					idx <= idx + 1'b1;
					if (&idx) begin
						state <= S_FINAL;
					end
				end
				S_FINAL: begin
					// One cycle for the last result to land
					idx <= idx + 1'b1;
					if (idx[0]) begin
						state <= S_FINISH;
					end
				end
				S_FINISH: begin
					// No legal move keeps the start boards
					if (final_d && res_valid) begin
						new_red <= res_red;
						new_blue <= res_blue;
					end else begin
						new_red <= cur_red;
						new_blue <= cur_blue;
					end
					best_x <= best_x_in;
					best_y <= best_y_in;
					no_move <= ~found;
					done <= 1'b1;
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/move_apply.sv
`timescale 1ns/10ps

module move_apply (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [othello_pkg::COORD_BITS-1:0]    cand_x,
	input  logic [othello_pkg::COORD_BITS-1:0]    cand_y,
	input  logic                                  cand_valid,
	input  logic [othello_pkg::BOARD_BITS-1:0]    cur_red,
	input  logic [othello_pkg::BOARD_BITS-1:0]    cur_blue,
	input  logic                                  player,
	output logic [othello_pkg::BOARD_BITS-1:0]    res_red,
	output logic [othello_pkg::BOARD_BITS-1:0]    res_blue,
	output logic [othello_pkg::FLIP_BITS-1:0]     flips,
	output logic                                  res_valid
);

	//////////////////////////////
	// Ray walk
	//////////////////////////////

	// Opponent discs on one ray, kept only if an own disc closes the run
	function automatic logic [othello_pkg::BOARD_BITS-1:0] ray_mask(
		input logic [othello_pkg::COORD_BITS-1:0] x,
		input logic [othello_pkg::COORD_BITS-1:0] y,
		input int                                 dx,
		input int                                 dy,
		input logic [othello_pkg::BOARD_BITS-1:0] own,
		input logic [othello_pkg::BOARD_BITS-1:0] opp
	);
		logic [othello_pkg::BOARD_BITS-1:0] run;
		logic [othello_pkg::BOARD_BITS-1:0] hit;
		logic                               walking;
		int                                 px;
		int                                 py;
		int                                 sq;
		run = '0;
		hit = '0;
		walking = 1'b1;
		for (int k = 1; k < 8; k++) begin
			px = int'(x) + k * dx;
			py = int'(y) + k * dy;
			sq = py * 8 + px;
			if (walking) begin
				if (px < 0 || px > 7 || py < 0 || py > 7) begin
					// Ran off the edge, run is open
					walking = 1'b0;
				end else if (opp[sq]) begin
					run[sq] = 1'b1;
				end else begin
					// Own disc brackets the run
					// an empty square drops it
					if (own[sq]) begin
						hit = run;
					end
					walking = 1'b0;
				end
			end
		end
		return hit;
	endfunction

	//////////////////////////////
	// Flip mask and new boards
	//////////////////////////////

	logic [othello_pkg::BOARD_BITS-1:0] own;
	logic [othello_pkg::BOARD_BITS-1:0] opp;
	logic [othello_pkg::BOARD_BITS-1:0] cand_bit;
	logic [othello_pkg::BOARD_BITS-1:0] ray_all;
	logic [othello_pkg::BOARD_BITS-1:0] flip_mask;
	logic [othello_pkg::BOARD_BITS-1:0] next_own;
	logic [othello_pkg::BOARD_BITS-1:0] next_opp;
	logic [othello_pkg::FLIP_BITS-1:0]  flip_cnt;
	logic                               occupied;
	logic                               legal;

	// Side to move, player 0 is red
	assign own = player ? cur_blue : cur_red;
	assign opp = player ? cur_red : cur_blue;

	assign cand_bit = {{(othello_pkg::BOARD_BITS-1){1'b0}}, 1'b1} << {cand_y, cand_x};
	assign occupied = |((cur_red | cur_blue) & cand_bit);

	always_comb begin
		ray_all = '0;
		// All eight neighbours as directions
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				if (dx != 0 || dy != 0) begin
					ray_all = ray_all | ray_mask(cand_x, cand_y, dx, dy, own, opp);
				end
			end
		end
	end

	// Occupied candidate turns nothing
	assign flip_mask = occupied ? '0 : ray_all;
	assign legal = |flip_mask;

	// Disc count
	always_comb begin
		flip_cnt = '0;
		for (int i = 0; i < othello_pkg::BOARD_BITS; i++) begin
			if (flip_mask[i]) begin
				flip_cnt = flip_cnt + 1'b1;
			end
		end
	end

	// Place and flip only on a legal square
	assign next_own = legal ? (own | flip_mask | cand_bit) : own;
	assign next_opp = legal ? (opp & ~flip_mask) : opp;

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		res_red <= player ? next_opp : next_own;
		res_blue <= player ? next_own : next_opp;
		flips <= flip_cnt;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= cand_valid;
		end
	end

endmodule

// File: hw/move_select.sv
`timescale 1ns/10ps

module move_select (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  sweep_start,
	input  logic                                  res_valid,
	input  logic [othello_pkg::FLIP_BITS-1:0]     flips,
	input  logic [othello_pkg::WEIGHT_BITS-1:0]   weight,
	input  logic [othello_pkg::COORD_BITS-1:0]    sel_x,
	input  logic [othello_pkg::COORD_BITS-1:0]    sel_y,
	output logic                                  found,
	output logic [othello_pkg::COORD_BITS-1:0]    best_x,
	output logic [othello_pkg::COORD_BITS-1:0]    best_y,
	output logic [othello_pkg::SCORE_BITS-1:0]    best_score
);

	logic [othello_pkg::SCORE_BITS-1:0] score;
	logic                               legal;
	logic                               better;

	//////////////////////////////
	// Score
	//////////////////////////////

	// Flips plus positional weight
	assign score = {{(othello_pkg::SCORE_BITS-othello_pkg::FLIP_BITS){1'b0}}, flips}
		+ {{(othello_pkg::SCORE_BITS-othello_pkg::WEIGHT_BITS){1'b0}}, weight};

	// Zero flips means illegal, occupied squares included
	assign legal = (flips != '0);

	// Strictly greater, so the earlier square wins a tie
	// Legal score is at least 1, beats the cleared best
	assign better = res_valid && legal && (score > best_score);

	//////////////////////////////
	// Best so far
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || sweep_start) begin
			found <= 1'b0;
			best_score <= '0;
			best_x <= '0;
			best_y <= '0;
		end else if (better) begin
			found <= 1'b1;
			best_score <= score;
			best_x <= sel_x;
			best_y <= sel_y;
		end
	end

endmodule

// File: hw/othello_ai.sv
`timescale 1ns/10ps

module othello_ai (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  go,
	input  logic [othello_pkg::BOARD_BITS-1:0]    init_red,
	input  logic [othello_pkg::BOARD_BITS-1:0]    init_blue,
	input  logic                                  init_player,
	output logic                                  done,
	output logic                                  busy,
	output logic                                  no_move,
	output logic [othello_pkg::COORD_BITS-1:0]    best_x,
	output logic [othello_pkg::COORD_BITS-1:0]    best_y,
	output logic [othello_pkg::BOARD_BITS-1:0]    new_red,
	output logic [othello_pkg::BOARD_BITS-1:0]    new_blue
);

	// Candidate stage
	logic [othello_pkg::COORD_BITS-1:0]  cand_x;
	logic [othello_pkg::COORD_BITS-1:0]  cand_y;
	logic                                cand_valid;
	logic                                sweep_start;
	logic [othello_pkg::BOARD_BITS-1:0]  cur_red;
	logic [othello_pkg::BOARD_BITS-1:0]  cur_blue;
	logic                                player;

	// Result stage
	logic [othello_pkg::BOARD_BITS-1:0]  res_red;
	logic [othello_pkg::BOARD_BITS-1:0]  res_blue;
	logic [othello_pkg::FLIP_BITS-1:0]   flips;
	logic                                res_valid;
	logic [othello_pkg::WEIGHT_BITS-1:0] weight;
	logic                                w_valid;

	// Selector
	logic [othello_pkg::COORD_BITS-1:0]  sel_x;
	logic [othello_pkg::COORD_BITS-1:0]  sel_y;
	logic                                sel_valid;
	logic                                found;
	logic [othello_pkg::COORD_BITS-1:0]  sel_best_x;
	logic [othello_pkg::COORD_BITS-1:0]  sel_best_y;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	// final_cand stays inside the sequencer
	ai_sequencer ai_sequencer_inst (
		.clk         (clk),
		.rst         (rst),
		.go          (go),
		.init_red    (init_red),
		.init_blue   (init_blue),
		.init_player (init_player),
		.found       (found),
		.best_x_in   (sel_best_x),
		.best_y_in   (sel_best_y),
		.res_red     (res_red),
		.res_blue    (res_blue),
		.res_valid   (res_valid),
		.w_valid     (w_valid),
		.cand_x      (cand_x),
		.cand_y      (cand_y),
		.cand_valid  (cand_valid),
		.final_cand  (),
		.sweep_start (sweep_start),
		.cur_red     (cur_red),
		.cur_blue    (cur_blue),
		.player      (player),
		.sel_x       (sel_x),
		.sel_y       (sel_y),
		.sel_valid   (sel_valid),
		.done        (done),
		.busy        (busy),
		.no_move     (no_move),
		.new_red     (new_red),
		.new_blue    (new_blue),
		.best_x      (best_x),
		.best_y      (best_y)
	);

	//////////////////////////////
	// Per square pipeline
	//////////////////////////////

	move_apply move_apply_inst (
		.clk        (clk),
		.rst        (rst),
		.cand_x     (cand_x),
		.cand_y     (cand_y),
		.cand_valid (cand_valid),
		.cur_red    (cur_red),
		.cur_blue   (cur_blue),
		.player     (player),
		.res_red    (res_red),
		.res_blue   (res_blue),
		.flips      (flips),
		.res_valid  (res_valid)
	);

	square_weight square_weight_inst (
		.clk        (clk),
		.rst        (rst),
		.cand_x     (cand_x),
		.cand_y     (cand_y),
		.cand_valid (cand_valid),
		.weight     (weight),
		.w_valid    (w_valid)
	);

	// Best score is only compared internally
	move_select move_select_inst (
		.clk         (clk),
		.rst         (rst),
		.sweep_start (sweep_start),
		.res_valid   (sel_valid),
		.flips       (flips),
		.weight      (weight),
		.sel_x       (sel_x),
		.sel_y       (sel_y),
		.found       (found),
		.best_x      (sel_best_x),
		.best_y      (sel_best_y),
		.best_score  ()
	);

endmodule

// File: hw/othello_pkg.sv
package othello_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// One bit per square, index y*8+x
	localparam int BOARD_BITS = 64;

	// Row or column number
	localparam int COORD_BITS = 3;

	// Square index {y, x}
	localparam int INDEX_BITS = 6;

	// At most 18 discs turn over in one move
	localparam int FLIP_BITS = 5;

	// Largest table entry
	localparam int WEIGHT_BITS = 5;

	// Corner weight 20 plus 18 flips still fits
	localparam int SCORE_BITS = 6;

	//////////////////////////////
	// Positional weights
	//////////////////////////////

	// Corners 20
	// Corner neighbours on the edge or diagonal 0
	// Rest of the edge 6, inner squares 3
	localparam logic [WEIGHT_BITS-1:0] SQUARE_WEIGHT [0:BOARD_BITS-1] = '{
		// y = 0
		5'd20, 5'd0,  5'd6,  5'd6,  5'd6,  5'd6,  5'd0,  5'd20,
		// y = 1
		5'd0,  5'd0,  5'd3,  5'd3,  5'd3,  5'd3,  5'd0,  5'd0,
		// y = 2
		5'd6,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd6,
		// y = 3
		5'd6,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd6,
		// y = 4
		5'd6,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd6,
		// y = 5
		5'd6,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd3,  5'd6,
		// y = 6
		5'd0,  5'd0,  5'd3,  5'd3,  5'd3,  5'd3,  5'd0,  5'd0,
		// y = 7
		5'd20, 5'd0,  5'd6,  5'd6,  5'd6,  5'd6,  5'd0,  5'd20
	};

	//////////////////////////////
	// Opening position
	//////////////////////////////

	// Red on (3,3) and (4,4)
	localparam logic [BOARD_BITS-1:0] OPEN_RED = 64'h0000_0010_0800_0000;

	// Blue on (4,3) and (3,4)
	localparam logic [BOARD_BITS-1:0] OPEN_BLUE = 64'h0000_0008_1000_0000;

endpackage

// File: hw/square_weight.sv
`timescale 1ns/10ps

module square_weight (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [othello_pkg::COORD_BITS-1:0]    cand_x,
	input  logic [othello_pkg::COORD_BITS-1:0]    cand_y,
	input  logic                                  cand_valid,
	output logic [othello_pkg::WEIGHT_BITS-1:0]   weight,
	output logic                                  w_valid
);

	// Table index, same layout as the boards
	logic [othello_pkg::INDEX_BITS-1:0] cand_idx;

	assign cand_idx = {cand_y, cand_x};

	//////////////////////////////
	// Lookup, one cycle
	//////////////////////////////

	// Registered to line up with the flip count
	always_ff @(posedge clk) begin
		weight <= othello_pkg::SQUARE_WEIGHT[cand_idx];
	end

	// Valid follows the candidate
	always_ff @(posedge clk) begin
		if (rst) begin
			w_valid <= 1'b0;
		end else begin
			w_valid <= cand_valid;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_othello_ai --Mdir obj_dir -o tb_othello_ai > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_othello_ai > sim.log 2>&1
cat sim.log

# The run fails when the log holds the fail message
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// File: sim.f
hw/othello_pkg.sv
hw/move_apply.sv
hw/square_weight.sv
hw/move_select.sv
hw/ai_sequencer.sv
hw/othello_ai.sv
+incdir+sim
sim/tb_othello_ai.sv

// File: sim/othello_ref.svh
`ifndef OTHELLO_REF_SVH
`define OTHELLO_REF_SVH

//////////////////////////////
// Expected results
//////////////////////////////

// Weight from the square's place on the board
function automatic int positional_weight(input int x, input int y);
	logic edge_x;
	logic edge_y;
	logic near_x;
	logic near_y;
	edge_x = (x == 0) || (x == 7);
	edge_y = (y == 0) || (y == 7);
	// Within one step of a corner
	near_x = (x <= 1) || (x >= 6);
	near_y = (y <= 1) || (y >= 6);
	if (edge_x && edge_y) begin
		return 20;
	end
	if (near_x && near_y) begin
		return 0;
	end
	if (edge_x || edge_y) begin
		return 6;
	end
	return 3;
endfunction

// Discs that turn over when the player takes (x, y)
function automatic logic [63:0] flipped_discs(input logic [63:0] red, input logic [63:0] blue,
		input logic player, input int x, input int y);
	int          step_x [0:7] = '{1, 1, 0, -1, -1, -1, 0, 1};
	int          step_y [0:7] = '{0, 1, 1, 1, 0, -1, -1, -1};
	logic [63:0] own;
	logic [63:0] opp;
	logic [63:0] occ;
	logic [63:0] line;
	logic [63:0] total;
	int          cx;
	int          cy;
	own = player ? blue : red;
	opp = player ? red : blue;
	occ = red | blue;
	total = '0;
	if (occ[y * 8 + x]) begin
		return '0;
	end
	for (int d = 0; d < 8; d++) begin
		line = '0;
		cx = x + step_x[d];
		cy = y + step_y[d];
		// Run of opponent discs
		while (cx >= 0 && cx < 8 && cy >= 0 && cy < 8 && opp[cy * 8 + cx]) begin
			line[cy * 8 + cx] = 1'b1;
			cx = cx + step_x[d];
			cy = cy + step_y[d];
		end
		// Kept only when closed by an own disc
		if (cx >= 0 && cx < 8 && cy >= 0 && cy < 8 && own[cy * 8 + cx]) begin
			total = total | line;
		end
	end
	return total;
endfunction

// First square with the highest score, flips plus weight
function automatic void best_square(input logic [63:0] red, input logic [63:0] blue,
		input logic player, output logic found, output int bx, output int by);
	int n;
	int score;
	int best;
	found = 1'b0;
	best = 0;
	bx = 0;
	by = 0;
	for (int i = 0; i < 64; i++) begin
		n = $countones(flipped_discs(red, blue, player, i % 8, i / 8));
		score = n + positional_weight(i % 8, i / 8);
		if (n > 0 && score > best) begin
			found = 1'b1;
			best = score;
			bx = i % 8;
			by = i / 8;
		end
	end
endfunction

// Boards after the player takes (x, y)
function automatic void apply_square(input logic [63:0] red, input logic [63:0] blue,
		input logic player, input int x, input int y,
		output logic [63:0] out_red, output logic [63:0] out_blue);
	logic [63:0] mask;
	logic [63:0] put;
	mask = flipped_discs(red, blue, player, x, y);
	put = 64'd1 << (y * 8 + x);
	if (player) begin
		out_blue = blue | mask | put;
		out_red = red & ~mask;
	end else begin
		out_red = red | mask | put;
		out_blue = blue & ~mask;
	end
endfunction

`endif

// File: sim/tb_othello_ai.sv
`timescale 1ns/10ps

module tb_othello_ai;

	logic                                  clk = 1'b0;
	logic                                  rst;
	logic                                  go;
	logic [othello_pkg::BOARD_BITS-1:0]    init_red;
	logic [othello_pkg::BOARD_BITS-1:0]    init_blue;
	logic                                  init_player;
	logic                                  done;
	logic                                  busy;
	logic                                  no_move;
	logic [othello_pkg::COORD_BITS-1:0]    best_x;
	logic [othello_pkg::COORD_BITS-1:0]    best_y;
	logic [othello_pkg::BOARD_BITS-1:0]    new_red;
	logic [othello_pkg::BOARD_BITS-1:0]    new_blue;

	int seed = 25239;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	`include "othello_ref.svh"

	othello_ai othello_ai_inst (
		.clk         (clk),
		.rst         (rst),
		.go          (go),
		.init_red    (init_red),
		.init_blue   (init_blue),
		.init_player (init_player),
		.done        (done),
		.busy        (busy),
		.no_move     (no_move),
		.best_x      (best_x),
		.best_y      (best_y),
		.new_red     (new_red),
		.new_blue    (new_blue)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic compare_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			$display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("ERROR: %s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests_run, name, (errors == errors_before) ? "ok" : "failed");
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// go for one cycle with the start position
	task automatic start_search(input logic [63:0] red, input logic [63:0] blue, input logic pl);
		@(posedge clk);
		init_red <= red;
		init_blue <= blue;
		init_player <= pl;
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
	endtask

	// Sampled on the falling edge, away from the DUT's updates
	task automatic wait_for_done(output logic seen);
		seen = 1'b0;
		for (int n = 0; n < 200 && !seen; n++) begin
			@(negedge clk);
			seen = done;
		end
		expect_true(seen, "done did not arrive within 200 cycles");
	endtask

	// DUT outputs against the reference for one start position
	task automatic check_outcome(input logic [63:0] red, input logic [63:0] blue, input logic pl);
		logic        found;
		int          bx;
		int          by;
		logic [63:0] exp_red;
		logic [63:0] exp_blue;
		best_square(red, blue, pl, found, bx, by);
		exp_red = red;
		exp_blue = blue;
		if (found) begin
			apply_square(red, blue, pl, bx, by, exp_red, exp_blue);
			compare_value("best_x", best_x, bx);
			compare_value("best_y", best_y, by);
		end
		compare_value("no_move", no_move, !found);
		compare_value("new_red", new_red, exp_red);
		compare_value("new_blue", new_blue, exp_blue);
	endtask

	task automatic search_and_check(input logic [63:0] red, input logic [63:0] blue,
			input logic pl);
		logic seen;
		start_search(red, blue, pl);
		wait_for_done(seen);
		if (seen) begin
			check_outcome(red, blue, pl);
		end
	endtask

	// Half the squares empty, the rest split between the sides
	task automatic random_board(output logic [63:0] red, output logic [63:0] blue,
			output logic pl);
		int pick;
		red = '0;
		blue = '0;
		for (int i = 0; i < 64; i++) begin
			pick = $random(seed) & 3;
			red[i] = (pick == 2);
			blue[i] = (pick == 3);
		end
		pl = $random(seed) & 1;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		logic [63:0] red;
		logic [63:0] blue;
		logic        pl;
		logic        seen;
		int          mark;
		int          extra;
		rst <= 1'b1;
		go <= 1'b0;
		init_red <= '0;
		init_blue <= '0;
		init_player <= 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// Idle outputs after reset
		mark = errors;
		@(negedge clk);
		compare_value("done", done, 1'b0);
		compare_value("busy", busy, 1'b0);
		compare_value("no_move", no_move, 1'b0);
		compare_value("new_red", new_red, othello_pkg::OPEN_RED);
		compare_value("new_blue", new_blue, othello_pkg::OPEN_BLUE);
		report_test("after reset", mark);

		// Four squares tie at 4, lowest index (4,2) wins
		mark = errors;
		search_and_check(othello_pkg::OPEN_RED, othello_pkg::OPEN_BLUE, 1'b0);
		compare_value("best_x", best_x, 3'd4);
		compare_value("best_y", best_y, 3'd2);
		report_test("opening red", mark);

		mark = errors;
		for (int t = 0; t < 20; t++) begin
			random_board(red, blue, pl);
			search_and_check(red, blue, pl);
		end
		report_test("random boards", mark);

		// Lone blue disc on the edge, red cannot bracket it
		mark = errors;
		search_and_check(64'h1, 64'h8000, 1'b0);
		compare_value("no_move", no_move, 1'b1);
		report_test("no legal move", mark);

		// Corner takes one disc, (4,4) takes four, corner still scores higher
		mark = errors;
		red = (64'd1 << 2) | (64'd1 << 12) | (64'd1 << 33);
		blue = (64'd1 << 1) | (64'd1 << 20) | (64'd1 << 28) | (64'd1 << 34) | (64'd1 << 35);
		search_and_check(red, blue, 1'b0);
		compare_value("best_x", best_x, 3'd0);
		compare_value("best_y", best_y, 3'd0);
		report_test("corner against inner", mark);

		// Second go lands mid sweep with another position
		mark = errors;
		start_search(othello_pkg::OPEN_RED, othello_pkg::OPEN_BLUE, 1'b1);
		@(negedge clk);
		expect_true(busy, "busy low during the sweep");
		start_search(red, blue, 1'b0);
		wait_for_done(seen);
		if (seen) begin
			check_outcome(othello_pkg::OPEN_RED, othello_pkg::OPEN_BLUE, 1'b1);
		end
		extra = 0;
		for (int n = 0; n < 100; n++) begin
			@(negedge clk);
			extra += done;
		end
		expect_true(extra == 0, "a second done followed the ignored go");
		report_test("go while busy", mark);

		$display("tests %0d, failed %0d, check failures %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
